// ==== bench/BackendTb.sv ====
`include "backend_consts.svh"

module BackendTb;
    timeunit 1ns;
    timeprecision 1ps;
    import BackendPkg::*;

    localparam int NumTags = 1 << `TAG_W;

    logic      clk = 1'b0;
    logic      rst = 1'b1;
    logic      dispatchValid;
    DispatchOp dispatchOp;
    logic      dispatchReady;
    ResultBus  resultBus [2];

    // Parsed data lines.
    logic [7:0]  kinds [64];
    logic [31:0] fields [64][7];
    int numLines = 0;
    int numOps = 0;
    int pauseCycles = 0;
    bit loaded = 1'b0;

    // Expected results indexed by tag.
    logic [31:0] expVal [NumTags];
    logic [31:0] expRd [NumTags];
    logic [31:0] expBus [NumTags];
    bit inFlight [NumTags];
    int outstanding = 0;
    logic [`TAG_W-1:0] tag = `TAG_W'd1;

    int valErrors = 0;
    int otherErrors = 0;
    int stalls = 0;

    Backend DUT (
        .clk           (clk),
        .rst           (rst),
        .dispatchValid (dispatchValid),
        .dispatchOp    (dispatchOp),
        .dispatchReady (dispatchReady),
        .resultBus     (resultBus)
    );

    always #20 clk = ~clk;

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            valErrors++;
        end
    endtask

    task automatic finishRun();
        $display("Errors: %0d value, %0d other", valErrors, otherErrors);
        if (valErrors + otherErrors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    task automatic loadStimulus();
        int fd;
        int n;
        string line;
        logic [7:0] kind;
        fd = $fopen("bench/backend_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/backend_testdata.txt");
            otherErrors++;
            finishRun();
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                kind = "#";
                if (n > 0) begin
                    n = $sscanf(line, "%c", kind);
                end
                if (kind == "O" || kind == "P" || kind == "R") begin
                    n = $sscanf(line, "%c %h %h %h %h %h %h %h", kinds[numLines],
                        fields[numLines][0], fields[numLines][1], fields[numLines][2],
                        fields[numLines][3], fields[numLines][4], fields[numLines][5],
                        fields[numLines][6]);
                    if (kind == "O") begin
                        numOps++;
                    end else begin
                        pauseCycles += fields[numLines][0];
                    end
                    numLines++;
                end
            end
            $fclose(fd);
            loaded = 1'b1;
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #2;
        end
    endtask

    // Holds the op until accepted, then books its tag.
    task automatic sendOp(input int i);
        DispatchOp op;
        op.opcode = Opcode'(fields[i][0][3:0]);
        op.rd     = fields[i][1][RegW-1:0];
        op.rs1    = fields[i][2][RegW-1:0];
        op.rs2    = fields[i][3][RegW-1:0];
        op.useImm = fields[i][4][0];
        op.imm    = fields[i][5];
        dispatchOp    = op;
        dispatchValid = 1'b1;
        @(negedge clk);
        while (!dispatchReady) begin
            stalls++;
            @(negedge clk);
        end
        @(posedge clk);
        expVal[tag] = fields[i][6];
        expRd[tag]  = op.rd;
        expBus[tag] = (op.opcode == OpMul) ? 1 : 0;
        inFlight[tag] = 1'b1;
        outstanding++;
        tag = (tag == '1) ? `TAG_W'd1 : tag + `TAG_W'd1;
        #2 dispatchValid = 1'b0;
    endtask

    // Results may come back in any order.
    always @(negedge clk) begin
        string sig;
        if (!rst) begin
            for (int k = 0; k < 2; k++) begin
                if (resultBus[k].valid && !inFlight[resultBus[k].tag]) begin
                    $display("Bus %0d carried tag %0d with no op in flight", k,
                        resultBus[k].tag);
                    otherErrors++;
                end else if (resultBus[k].valid) begin
                    sig = $sformatf("resultBus[%0d] tag %0d", k, resultBus[k].tag);
                    checkVal({sig, " rd"}, resultBus[k].rd, expRd[resultBus[k].tag]);
                    checkVal({sig, " value"}, resultBus[k].value, expVal[resultBus[k].tag]);
                    checkVal({sig, " bus"}, k, expBus[resultBus[k].tag]);
                    inFlight[resultBus[k].tag] = 1'b0;
                    outstanding--;
                end
            end
        end
    end

    initial begin
        int seedDummy;
        seedDummy = $urandom(32'h8c1b_3ce4);
        dispatchValid = 1'b0;
        dispatchOp = '0;
        loadStimulus();
        repeat (5) @(posedge clk);
        #2 rst = 1'b0;
        // Nothing may complete before the first dispatch.
        repeat (3) begin
            @(negedge clk);
            if (resultBus[0].valid !== 1'b0 || resultBus[1].valid !== 1'b0) begin
                $display("A result bus went valid before any dispatch");
                otherErrors++;
            end
        end
        if (dispatchReady !== 1'b1) begin
            $display("dispatchReady stayed low after reset");
            otherErrors++;
        end
        idle(1);
        for (int i = 0; i < numLines; i++) begin
            if (kinds[i] == "O") begin
                sendOp(i);
            end else if (kinds[i] == "P") begin
                idle(fields[i][0]);
            end else begin
                idle($urandom_range(fields[i][0], 0));
            end
        end
        wait (outstanding == 0);
        // Catch any duplicate results.
        idle(10);
        if (stalls == 0) begin
            $display("dispatchReady never dropped, back-pressure was not exercised");
            otherErrors++;
        end
        finishRun();
    end

    initial begin
        wait (loaded);
        repeat (200 * numOps + pauseCycles + 1000) @(posedge clk);
        $display("Watchdog timeout with %0d results outstanding", outstanding);
        otherErrors++;
        finishRun();
    end

endmodule

// ==== bench/backend_testdata.txt ====
# O opcode rd rs1 rs2 useImm imm expected (hex); opcode 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl 7 slt 8 mul
# P n idles dispatch for n cycles; R n idles for a random 0..n cycles
O 0 1 0 0 1 00000005 00000005
O 0 2 0 0 1 00000007 00000007
O 0 3 0 0 1 fffffffd fffffffd
P 4
O 5 5 1 0 1 00000004 00000050
O 6 6 3 0 1 0000001c 0000000f
O 7 7 3 1 0 00000000 00000001
O 4 8 2 0 1 0000000f 00000008
O 2 9 3 0 1 000000ff 000000fd
O 3 a 1 0 1 00000f00 00000f05
R 3
O 0 b 1 2 0 00000000 0000000c
O 0 b b 0 1 00000001 0000000d
O 1 c b 1 0 00000000 00000008
O 5 c c 0 1 00000002 00000020
R 2
O 8 d 1 2 0 00000000 00000023
O 0 e 0 0 1 00000011 00000011
O 8 f d d 0 00000000 000004c9
O 0 1 f 0 1 00000001 000004ca
P 6
O 8 2 2 0 1 00000003 00000015
O 8 2 2 0 1 00000003 0000003f
O 8 3 2 0 1 00000002 0000007e
O 8 4 2 0 1 00000002 0000007e
O 8 5 2 0 1 00000004 000000fc
O 8 6 3 0 1 00000003 0000017a
O 8 7 2 2 0 00000000 00000f81
P 6
O 8 9 1 0 1 00000002 00000994
O 0 9 0 0 1 00000033 00000033
P 6
O 0 a 9 0 1 00000001 00000034

// ==== design/Backend.sv ====
`include "backend_consts.svh"

module Backend (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dispatchValid,
    input  BackendPkg::DispatchOp dispatchOp,
    output logic                  dispatchReady,
    output BackendPkg::ResultBus  resultBus [2]
);
    import BackendPkg::*;

    // Renamed ops towards each station.
    UOp     aluEnq;
    UOp     mulEnq;
    logic   aluFull;
    logic   mulFull;

    // Station to unit, no handshake.
    IssueOp aluIssue;
    IssueOp mulIssue;

    RenameUnit rename (
        .clk           (clk),
        .rst           (rst),
        .dispatchValid (dispatchValid),
        .dispatchOp    (dispatchOp),
        .dispatchReady (dispatchReady),
        .aluFull       (aluFull),
        .mulFull       (mulFull),
        .aluEnq        (aluEnq),
        .mulEnq        (mulEnq),
        .resultBus     (resultBus)
    );

    ReservationStation #(
        .DEPTH (`RS_DEPTH)
    ) aluRs (
        .clk       (clk),
        .rst       (rst),
        .enq       (aluEnq),
        .resultBus (resultBus),
        .full      (aluFull),
        .issue     (aluIssue)
    );

    ReservationStation #(
        .DEPTH (`RS_DEPTH)
    ) mulRs (
        .clk       (clk),
        .rst       (rst),
        .enq       (mulEnq),
        .resultBus (resultBus),
        .full      (mulFull),
        .issue     (mulIssue)
    );

    // Bus 0 belongs to the ALU.
    IntAlu alu (
        .clk    (clk),
        .rst    (rst),
        .issue  (aluIssue),
        .result (resultBus[0])
    );

    // Bus 1 belongs to the multiplier.
    MulUnit mul (
        .clk    (clk),
        .rst    (rst),
        .issue  (mulIssue),
        .result (resultBus[1])
    );

endmodule

// ==== design/BackendPkg.sv ====
`include "backend_consts.svh"

package BackendPkg;

    // Width of a register index.
    localparam int RegW = $clog2(`NUM_REGS);

    typedef enum logic [3:0] {
        OpAdd = 4'd0,
        OpSub = 4'd1,
        OpAnd = 4'd2,
        OpOr  = 4'd3,
        OpXor = 4'd4,
        OpSll = 4'd5,
        OpSrl = 4'd6,
        OpSlt = 4'd7,
        OpMul = 4'd8
    } Opcode;

    // Decoded micro-op as it arrives at dispatch.
    typedef struct packed {
        Opcode            opcode;
        logic [RegW-1:0]  rd;
        logic [RegW-1:0]  rs1;
        logic [RegW-1:0]  rs2;
        logic [31:0]      imm;
        logic             useImm;
    } DispatchOp;

    // Value is only meaningful once tag is zero.
    typedef struct packed {
        logic [`TAG_W-1:0] tag;
        logic [31:0]       value;
    } Operand;

    // Renamed micro-op waiting in a station.
    typedef struct packed {
        logic              valid;
        Opcode             opcode;
        Operand            srcA;
        Operand            srcB;
        logic [`TAG_W-1:0] dstTag;
        logic [RegW-1:0]   rd;
    } UOp;

    typedef struct packed {
        logic              valid;
        Opcode             opcode;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [`TAG_W-1:0] dstTag;
        logic [RegW-1:0]   rd;
    } IssueOp;

    typedef struct packed {
        logic              valid;
        logic [`TAG_W-1:0] tag;
        logic [RegW-1:0]   rd;
        logic [31:0]       value;
    } ResultBus;

endpackage

// ==== design/IntAlu.sv ====
module IntAlu (
    input  logic                 clk,
    input  logic                 rst,
    input  BackendPkg::IssueOp   issue,
    output BackendPkg::ResultBus result
);
    import BackendPkg::*;

    logic [31:0] aluOut;
    logic [4:0]  shamt;

    // Shift amount from the low bits of b.
    assign shamt = issue.b[4:0];

    always_comb begin
        case (issue.opcode)
            OpAdd:   aluOut = issue.a + issue.b;
            OpSub:   aluOut = issue.a - issue.b;
            OpAnd:   aluOut = issue.a & issue.b;
            OpOr:    aluOut = issue.a | issue.b;
            OpXor:   aluOut = issue.a ^ issue.b;
            OpSll:   aluOut = issue.a << shamt;
            OpSrl:   aluOut = issue.a >> shamt;
            OpSlt:   aluOut = {31'b0, $signed(issue.a) < $signed(issue.b)};
            default: aluOut = '0;
        endcase
    end

    // Single registered stage onto result bus 0.
    always_ff @(posedge clk) begin
        if (rst) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= issue.valid;
        end
        result.tag   <= issue.dstTag;
        result.rd    <= issue.rd;
        result.value <= aluOut;
    end

    // Multiplies belong to the other unit.
    noMulInAlu: assert property (
        @(posedge clk) disable iff (rst)
        issue.valid |-> issue.opcode != OpMul
    ) else $error("mul routed to the ALU");

endmodule

// ==== design/MulUnit.sv ====
`include "backend_consts.svh"

module MulUnit (
    input  logic                 clk,
    input  logic                 rst,
    input  BackendPkg::IssueOp   issue,
    output BackendPkg::ResultBus result
);
    import BackendPkg::*;

    // One result record per pipeline stage.
    ResultBus pipe [`MUL_STAGES];

    logic [31:0] product;

    // Low word only.
    assign product = issue.a * issue.b;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `MUL_STAGES; s++) begin
                pipe[s].valid <= 1'b0;
            end
        end else begin
            pipe[0].valid <= issue.valid;
            for (int s = 1; s < `MUL_STAGES; s++) begin
                pipe[s].valid <= pipe[s-1].valid;
            end
        end

        pipe[0].tag   <= issue.dstTag;
        pipe[0].rd    <= issue.rd;
        pipe[0].value <= product;
        // Later stages give the multiplier array room to retime.
        for (int s = 1; s < `MUL_STAGES; s++) begin
            pipe[s].tag   <= pipe[s-1].tag;
            pipe[s].rd    <= pipe[s-1].rd;
            pipe[s].value <= pipe[s-1].value;
        end
    end

    assign result = pipe[`MUL_STAGES-1];

    // Station routing must keep other opcodes away.
    onlyMul: assert property (
        @(posedge clk) disable iff (rst)
        issue.valid |-> issue.opcode == OpMul
    ) else $error("non-mul opcode %0d entered the multiplier", issue.opcode);

endmodule

// ==== design/RenameUnit.sv ====
`include "backend_consts.svh"

module RenameUnit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dispatchValid,
    input  BackendPkg::DispatchOp dispatchOp,
    output logic                  dispatchReady,
    input  logic                  aluFull,
    input  logic                  mulFull,
    output BackendPkg::UOp        aluEnq,
    output BackendPkg::UOp        mulEnq,
    input  BackendPkg::ResultBus  resultBus [2]
);
    import BackendPkg::*;

    localparam int NumTags = 1 << `TAG_W;

    // Architectural state plus the tag each register is waiting on.
    logic [31:0]       regVal  [`NUM_REGS];
    logic [`TAG_W-1:0] pendTag [`NUM_REGS];
    logic [NumTags-1:0] tagBusy;

    logic [`TAG_W-1:0] nextTag;
    logic              armed;
    logic              tagFreed;
    logic              tagInTable;
    logic              isMul;
    logic              targetFull;
    logic              accept;
    UOp                uop;

    // Register read with bypass from the result buses.
    function automatic Operand lookup(input logic [RegW-1:0] src);
        Operand op;
        op.tag   = pendTag[src];
        op.value = regVal[src];
        for (int k = 0; k < 2; k++) begin
            if (op.tag != '0 && resultBus[k].valid && resultBus[k].tag == op.tag) begin
                op.tag   = '0;
                op.value = resultBus[k].value;
            end
        end
        return op;
    endfunction

    // Next tag counts as free if its result is on a bus right now.
    always_comb begin
        tagFreed = 1'b0;
        for (int k = 0; k < 2; k++) begin
            if (resultBus[k].valid && resultBus[k].tag == nextTag) begin
                tagFreed = 1'b1;
            end
        end
    end

    // Next tag still named as the pending writer of some register.
    always_comb begin
        tagInTable = 1'b0;
        for (int r = 0; r < `NUM_REGS; r++) begin
            if (pendTag[r] == nextTag) begin
                tagInTable = 1'b1;
            end
        end
    end

    assign isMul         = (dispatchOp.opcode == OpMul);
    assign targetFull    = isMul ? mulFull : aluFull;
    assign dispatchReady = armed && !targetFull && (!tagBusy[nextTag] || tagFreed);
    assign accept        = dispatchValid && dispatchReady;

    always_comb begin
        uop.valid  = accept;
        uop.opcode = dispatchOp.opcode;
        uop.srcA   = lookup(dispatchOp.rs1);
        if (dispatchOp.useImm) begin
            uop.srcB.tag   = '0;
            uop.srcB.value = dispatchOp.imm;
        end else begin
            uop.srcB = lookup(dispatchOp.rs2);
        end
        uop.dstTag = nextTag;
        uop.rd     = dispatchOp.rd;

        // Steer to one station by opcode.
        aluEnq       = uop;
        aluEnq.valid = accept && !isMul;
        mulEnq       = uop;
        mulEnq.valid = accept && isMul;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `NUM_REGS; r++) begin
                regVal[r]  <= '0;
                pendTag[r] <= '0;
            end
            tagBusy <= '0;
            nextTag <= `TAG_W'd1;
            armed   <= 1'b0;
        end else begin
            armed <= 1'b1;

            // Retire results. Only the newest writer of a register lands.
            for (int k = 0; k < 2; k++) begin
                if (resultBus[k].valid) begin
                    tagBusy[resultBus[k].tag] <= 1'b0;
                    if (pendTag[resultBus[k].rd] == resultBus[k].tag) begin
                        regVal[resultBus[k].rd]  <= resultBus[k].value;
                        pendTag[resultBus[k].rd] <= '0;
                    end
                end
            end

            // Allocation comes last so a new writer overrides a retiring one.
            if (accept) begin
                tagBusy[nextTag]         <= 1'b1;
                pendTag[dispatchOp.rd]   <= nextTag;
                if (nextTag == '1) begin
                    nextTag <= `TAG_W'd1;
                end else begin
                    nextTag <= nextTag + `TAG_W'd1;
                end
            end
        end
    end

    // A tag in flight must not be handed out again.
    tagNotReused: assert property (
        @(posedge clk) disable iff (rst)
        accept |-> (!tagInTable || tagFreed)
    ) else $error("tag %0d allocated while still in flight", nextTag);

endmodule

// ==== design/ReservationStation.sv ====
`include "backend_consts.svh"

module ReservationStation #(
    parameter int DEPTH = `RS_DEPTH
) (
    input  logic                 clk,
    input  logic                 rst,
    input  BackendPkg::UOp       enq,
    input  BackendPkg::ResultBus resultBus [2],
    output logic                 full,
    output BackendPkg::IssueOp   issue
);
    import BackendPkg::*;

    localparam int IdxW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    UOp slots [DEPTH];

    logic [IdxW-1:0] freeIdx;
    logic [IdxW-1:0] issueIdx;
    logic            issueHit;

    // Lowest free slot. Scanning downward leaves the lowest match.
    always_comb begin
        full    = 1'b1;
        freeIdx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!slots[i].valid) begin
                full    = 1'b0;
                freeIdx = IdxW'(i);
            end
        end
    end

    // Lowest entry with both operands present.
    always_comb begin
        issueHit = 1'b0;
        issueIdx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (slots[i].valid && slots[i].srcA.tag == '0 && slots[i].srcB.tag == '0) begin
                issueHit = 1'b1;
                issueIdx = IdxW'(i);
            end
        end
    end

    always_comb begin
        issue.valid  = issueHit;
        issue.opcode = slots[issueIdx].opcode;
        issue.a      = slots[issueIdx].srcA.value;
        issue.b      = slots[issueIdx].srcB.value;
        issue.dstTag = slots[issueIdx].dstTag;
        issue.rd     = slots[issueIdx].rd;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                slots[i].valid <= 1'b0;
            end
        end else begin
            // Snoop both buses for operands still waiting.
            for (int i = 0; i < DEPTH; i++) begin
                for (int k = 0; k < 2; k++) begin
                    if (slots[i].valid && resultBus[k].valid) begin
                        if (slots[i].srcA.tag != '0 &&
                            slots[i].srcA.tag == resultBus[k].tag) begin
                            slots[i].srcA.tag   <= '0;
                            slots[i].srcA.value <= resultBus[k].value;
                        end
                        if (slots[i].srcB.tag != '0 &&
                            slots[i].srcB.tag == resultBus[k].tag) begin
                            slots[i].srcB.tag   <= '0;
                            slots[i].srcB.value <= resultBus[k].value;
                        end
                    end
                end
            end

            // Issue frees its slot at the same edge.
            if (issueHit) begin
                slots[issueIdx].valid <= 1'b0;
            end

            // Enqueue always targets an empty slot, never the issuing one.
            if (enq.valid && !full) begin
                slots[freeIdx] <= enq;
            end
        end
    end

    noEnqWhenFull: assert property (
        @(posedge clk) disable iff (rst)
        enq.valid |-> !full
    ) else $error("enqueue into full station");

endmodule

// ==== design/backend_consts.svh ====
`ifndef BACKEND_CONSTS_SVH
`define BACKEND_CONSTS_SVH

// Architectural integer registers.
`define NUM_REGS 16

// Result tag width.
// Tag 0 marks an operand whose value is already present.
`define TAG_W 6

// Entries in each reservation station.
`define RS_DEPTH 4

// Cycles from multiplier issue to result bus.
`define MUL_STAGES 3

`endif

// ==== vlog.f ====
+incdir+design
design/BackendPkg.sv
design/RenameUnit.sv
design/ReservationStation.sv
design/IntAlu.sv
design/MulUnit.sv
design/Backend.sv
bench/BackendTb.sv
